/* list.f */
rv_isa_pkg.sv
dpc_pkg.sv
inst_predecode.sv
dpc_monitor.sv
issue_ctrl.sv
dpc_core_top.sv
tb_clk_gen.sv
dpc_monitor_chk.sv
tb_dpc_core.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_dpc_core
FILELIST  = list.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation finished: PASS

SRCS = $(shell grep -v '^+' $(FILELIST))
BIN  = $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_dpc_core.sv */
// Directed tests for the issue core, written for trace_depth 4 and long_lat 4.
// Upstream credits are mirrored at the falling edge; inputs change 1 ns after a rising edge.
// inst_id is expected to count every valid fetch from 0, flushed ones included.
`timescale 1ns/1ps

module tb_dpc_core;
	import rv_isa_pkg::*;
	import dpc_pkg::*;

	localparam int TD          = 4;
	localparam int LL          = 4;
	localparam int TIMEOUT_CYC = 2000; // six tests, each drains within about 300 cycles

	logic                    clk;
	logic                    resetn;
	logic                    flush;
	fetch_pkt_t              fetch;
	retire_pkt_t             retire;
	logic                    credit;
	logic [$clog2(TD+1)-1:0] credit_cnt;

	int          credits;
	int          credit_sum = 0;
	int          next_id    = 0;
	int          cyc        = 0;
	int          checks     = 0;
	int          value_errs = 0;
	int          other_errs = 0;
	int          ret_id[$];
	int          ret_rd[$];
	int          ret_long[$];
	int          ret_cyc[$];
	logic [31:0] rng_state  = 32'd44702;

	tb_clk_gen u_tb_clk_gen (
		.clk_o    (clk),
		.resetn_o (resetn)
	);

	dpc_core_top #(
		.trace_depth (TD),
		.long_lat    (LL),
		.en_bypass   (1)
	) u_dpc_core_top (
		.clk          (clk),
		.resetn       (resetn),
		.flush_i      (flush),
		.fetch_i      (fetch),
		.retire_o     (retire),
		.credit_o     (credit),
		.credit_cnt_o (credit_cnt)
	);

	bind dpc_monitor dpc_monitor_chk #(.trace_depth(trace_depth)) u_dpc_monitor_chk (
		.clk         (clk),
		.resetn      (resetn),
		.enter_vld_i (enter_vld_i),
		.full_i      (full_o),
		.free_vec_i  (free_vec),
		.hazard_i    (hazard_o),
		.freed_cnt_i (freed_cnt_o)
	);

	always @(posedge clk)
	begin
		cyc = cyc + 1;
		if (cyc >= TIMEOUT_CYC)
		begin
			$display("ERROR: timeout after %0d cycles, the DUT stopped making progress", cyc);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	// upstream credit model and retire recorder
	always @(negedge clk)
	begin
		if (!resetn)
			credits = TD;
		else
		begin
			credits    = credits + int'(credit_cnt) - int'(fetch.valid);
			credit_sum = credit_sum + int'(credit_cnt);
			if (retire.valid)
			begin
				ret_id.push_back(int'(retire.inst_id));
				ret_rd.push_back(int'(retire.rd));
				ret_long.push_back(int'(retire.is_long));
				ret_cyc.push_back(cyc);
			end
			assert (credit == (credit_cnt != '0))
			else
			begin
				other_errs++;
				$display("ERROR: credit_o does not follow a nonzero credit count");
			end
		end
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic reg_idx_t pick_reg(input int lo, input int hi);
		rng_state = xorshift32(rng_state);
		return 5'(lo + int'(rng_state % 32'(hi - lo + 1)));
	endfunction

	function automatic logic [31:0] add_word(input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2);
		return {7'b0000000, rs2, rs1, 3'b000, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] mul_word(input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2);
		return {7'b0000001, rs2, rs1, 3'b000, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] lw_word(input reg_idx_t rd, input reg_idx_t rs1);
		return {12'd0, rs1, 3'b010, rd, OPC_LOAD};
	endfunction

	function automatic int ret_pos(input int id);
		for (int k = 0; k < ret_id.size(); k++)
			if (ret_id[k] == id)
				return k;
		return -1;
	endfunction

	task automatic check_eq(input string test, input string what, input int exp, input int act);
		checks++;
		assert (exp == act)
		else
		begin
			value_errs++;
			$display("CHECK FAILED: %s %s expected %0d actual %0d", test, what, exp, act);
		end
	endtask

	task automatic check_order(input string test, input string what, input int first,
		input int second);
		checks++;
		assert (first >= 0 && second >= 0 && first < second)
		else
		begin
			other_errs++;
			$display("ERROR: %s: %s", test, what);
		end
	endtask

	// long ops are LOAD and MUL, everything else retires as single-cycle
	task automatic check_retired(input string test, input int id, input reg_idx_t exp_rd,
		input logic exp_long, output int pos);
		pos = ret_pos(id);
		checks++;
		assert (pos >= 0)
		else
		begin
			other_errs++;
			$display("ERROR: %s: instruction %0d never retired", test, id);
		end
		if (pos >= 0)
		begin
			check_eq(test, "retire rd", int'(exp_rd), ret_rd[pos]);
			check_eq(test, "retire is_long", int'(exp_long), ret_long[pos]);
		end
	endtask

	// waits for credit, drives one word for one cycle
	task automatic fetch_one(input logic [31:0] word, output int id);
		while (credits == 0)
		begin
			@(posedge clk);
			#1;
		end
		fetch.valid = 1'b1;
		fetch.inst  = word;
		id          = next_id & 255;
		next_id++;
		@(posedge clk);
		#1;
		fetch.valid = 1'b0;
	endtask

	// stops once every credit is back, an excess shows up in the checks
	task automatic wait_drain();
		while (credits < TD)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic test_credits();
		int ids[TD];
		int pos;
		int base_cred;
		int base_ret;
		check_eq("credits", "credits after reset", TD, credits);
		check_eq("credits", "retire valid after reset", 0, int'(retire.valid));
		check_eq("credits", "credit_o after reset", 0, int'(credit));
		base_cred = credit_sum;
		base_ret  = ret_id.size();
		// consumers wait on the MUL, so nothing frees while sending
		fetch_one(mul_word(5'd10, 5'd1, 5'd2), ids[0]);
		for (int k = 1; k < TD; k++)
			fetch_one(add_word(5'(10 + k), 5'd10, 5'd3), ids[k]);
		check_eq("credits", "credits after trace_depth sends", 0, credits);
		wait_drain();
		check_retired("credits", ids[0], 5'd10, 1'b1, pos);
		for (int k = 1; k < TD; k++)
			check_retired("credits", ids[k], 5'(10 + k), 1'b0, pos);
		// one credit back for each retirement seen
		check_eq("credits", "credits returned", ret_id.size() - base_ret,
			credit_sum - base_cred);
		check_eq("credits", "final credits", TD, credits);
	endtask

	task automatic test_out_of_order();
		reg_idx_t s1;
		reg_idx_t s2;
		reg_idx_t d1;
		reg_idx_t d2;
		int       id_m;
		int       id_a;
		int       id_b;
		int       p_m;
		int       p_a;
		int       p_b;
		s1 = pick_reg(1, 9);
		s2 = pick_reg(1, 9);
		d1 = pick_reg(23, 31);
		d2 = pick_reg(23, 31);
		fetch_one(mul_word(5'd10, s1, s2), id_m);
		fetch_one(add_word(d1, s2, s1), id_a);
		fetch_one(add_word(d2, s1, s2), id_b);
		wait_drain();
		check_retired("ooo", id_m, 5'd10, 1'b1, p_m);
		check_retired("ooo", id_a, d1, 1'b0, p_a);
		check_retired("ooo", id_b, d2, 1'b0, p_b);
		check_order("ooo", "first ADD did not retire before the MUL", p_a, p_m);
		check_order("ooo", "second ADD did not retire before the MUL", p_b, p_m);
	endtask

	task automatic test_raw_load();
		int id_l;
		int id_a;
		int p_l;
		int p_a;
		fetch_one(lw_word(5'd12, pick_reg(1, 9)), id_l);
		fetch_one(add_word(5'd13, 5'd12, pick_reg(1, 9)), id_a);
		wait_drain();
		check_retired("raw", id_l, 5'd12, 1'b1, p_l);
		check_retired("raw", id_a, 5'd13, 1'b0, p_a);
		check_order("raw", "ADD reading the load result retired before the load", p_l, p_a);
	endtask

	task automatic test_waw();
		int id_m;
		int id_a;
		int p_m;
		int p_a;
		fetch_one(mul_word(5'd14, pick_reg(1, 9), pick_reg(1, 9)), id_m);
		fetch_one(add_word(5'd14, pick_reg(1, 9), pick_reg(1, 9)), id_a);
		wait_drain();
		check_retired("waw", id_m, 5'd14, 1'b1, p_m);
		check_retired("waw", id_a, 5'd14, 1'b0, p_a);
		check_order("waw", "ADD writing the MUL's rd retired before the MUL", p_m, p_a);
	endtask

	task automatic test_bypass();
		reg_idx_t s1;
		int       id_p;
		int       id_c;
		int       p_p;
		int       p_c;
		s1 = pick_reg(1, 9);
		fetch_one(add_word(5'd15, s1, pick_reg(1, 9)), id_p);
		fetch_one(add_word(5'd16, 5'd15, s1), id_c);
		wait_drain();
		check_retired("bypass", id_p, 5'd15, 1'b0, p_p);
		check_retired("bypass", id_c, 5'd16, 1'b0, p_c);
		if (p_p >= 0 && p_c >= 0)
			check_eq("bypass", "consumer retire cycle", ret_cyc[p_p] + 1, ret_cyc[p_c]);
		// x0 written by a long op must not hold back a reader or writer of x0
		fetch_one(mul_word(5'd0, s1, pick_reg(1, 9)), id_p);
		fetch_one(add_word(5'd0, 5'd0, s1), id_c);
		wait_drain();
		check_retired("bypass", id_p, 5'd0, 1'b1, p_p);
		check_retired("bypass", id_c, 5'd0, 1'b0, p_c);
		check_order("bypass", "ADD on x0 stalled behind the MUL writing x0", p_c, p_p);
	endtask

	task automatic test_flush();
		reg_idx_t d;
		int       id_m;
		int       id_x;
		int       id_n;
		int       base;
		int       pos;
		base = ret_id.size();
		fetch_one(mul_word(5'd19, pick_reg(1, 9), pick_reg(1, 9)), id_m);
		fetch_one(add_word(5'd20, 5'd19, pick_reg(1, 9)), id_x);
		fetch_one(add_word(5'd21, 5'd20, pick_reg(1, 9)), id_x);
		fetch_one(add_word(5'd22, 5'd21, pick_reg(1, 9)), id_x);
		flush = 1'b1; // MUL executing, the ADDs behind it
		@(posedge clk);
		#1;
		flush = 1'b0;
		wait_drain();
		repeat (LL + 4) @(posedge clk);
		#1;
		check_eq("flush", "retires after flush", 1, ret_id.size() - base);
		check_retired("flush", id_m, 5'd19, 1'b1, pos);
		check_eq("flush", "credits after flush", TD, credits);
		d = pick_reg(23, 31);
		fetch_one(add_word(d, pick_reg(1, 9), pick_reg(1, 9)), id_n);
		wait_drain();
		check_retired("flush", id_n, d, 1'b0, pos);
	endtask

	initial
	begin
		fetch = '0;
		flush = 1'b0;
		wait (resetn == 1'b1);
		@(posedge clk);
		#1;
		test_credits();
		test_out_of_order();
		test_raw_load();
		test_waw();
		test_bypass();
		test_flush();
		$display("checks: %0d, value errors: %0d, other errors: %0d",
			checks, value_errs, other_errs);
		if (value_errs == 0 && other_errs == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

/* dpc_monitor_chk.sv */
// Concurrent checks on the dependency monitor, bound in from the testbench.
// Needs the monitor's internal free_vec; all checks are off while resetn is low.
`timescale 1ns/1ps

module dpc_monitor_chk #(
	parameter int trace_depth = 4
)(
	input logic                             clk,
	input logic                             resetn,
	input logic                             enter_vld_i,
	input logic                             full_i,
	input logic [trace_depth-1:0]           free_vec_i,
	input dpc_pkg::hazard_t                 hazard_i,
	input logic [$clog2(trace_depth+1)-1:0] freed_cnt_i
);
	// upstream holds no credit while every entry is taken
	a_no_enter_when_full: assert property (@(posedge clk) disable iff (!resetn)
		full_i |-> !enter_vld_i)
		else $error("instruction entered while every table entry was taken");

	a_idle_no_hazard: assert property (@(posedge clk) disable iff (!resetn)
		(&free_vec_i) |-> (hazard_i == '0))
		else $error("hazard reported with an empty tracking table");

	a_freed_in_range: assert property (@(posedge clk) disable iff (!resetn)
		int'(freed_cnt_i) <= trace_depth)
		else $error("more entries freed in one cycle than the table holds");

endmodule

/* tb_clk_gen.sv */
// Testbench clock with an 8 ns period.
// resetn is held low for 8 cycles and is released 1 ns after a rising edge.
`timescale 1ns/1ps

module tb_clk_gen (
	output logic clk_o,
	output logic resetn_o
);
	initial
	begin
		clk_o    = 1'b0;
		resetn_o = 1'b0;
		repeat (8) @(posedge clk_o);
		#1 resetn_o = 1'b1;
	end

	always #4 clk_o = ~clk_o;

endmodule

/* dpc_core_top.sv */
// Hazard-tracking issue core. Upstream holds trace_depth credits after reset and
// spends one per valid fetch; credit_cnt_o gives them back.
`timescale 1ns/1ps

module dpc_core_top #(
	parameter int trace_depth = 4,
	parameter int long_lat    = 4,
	parameter int en_bypass   = 1
)(
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             flush_i,
	input  dpc_pkg::fetch_pkt_t              fetch_i,
	output dpc_pkg::retire_pkt_t             retire_o,
	output logic                             credit_o,
	output logic [$clog2(trace_depth+1)-1:0] credit_cnt_o
);
	import rv_isa_pkg::*;
	import dpc_pkg::*;

	reg_idx_t                         pd_rd;
	reg_idx_t                         pd_rs1;
	reg_idx_t                         pd_rs2;
	logic                             pd_rd_vld;
	logic                             pd_rs2_vld;
	logic                             pd_long;
	trace_entry_t                     pd_entry;
	trace_entry_t                     enter;
	logic                             enter_vld;
	inst_id_t                         dcd_id;
	logic                             dcd_vld;
	inst_id_t                         dsptc_id;
	logic                             dsptc_vld;
	inst_id_t                         retire_id;
	logic                             retire_vld;
	reg_idx_t                         chk_rs1;
	reg_idx_t                         chk_rs2;
	reg_idx_t                         chk_rd;
	hazard_t                          hazard;
	logic [$clog2(trace_depth+1)-1:0] freed_cnt;

	inst_predecode u_inst_predecode (
		.inst_i    (fetch_i.inst),
		.rd_o      (pd_rd),
		.rs1_o     (pd_rs1),
		.rs2_o     (pd_rs2),
		.rd_vld_o  (pd_rd_vld),
		.rs2_vld_o (pd_rs2_vld),
		.is_long_o (pd_long)
	);

	// unused indices become x0, inst_id is stamped by issue_ctrl
	assign pd_entry = '{
		rd:      pd_rd & {5{pd_rd_vld}},
		rs1:     pd_rs1,
		rs2:     pd_rs2 & {5{pd_rs2_vld}},
		is_long: pd_long,
		inst_id: '0
	};

	issue_ctrl #(
		.trace_depth (trace_depth),
		.long_lat    (long_lat)
	) u_issue_ctrl (
		.clk          (clk),
		.resetn       (resetn),
		.flush_i      (flush_i),
		.entry_i      (pd_entry),
		.entry_vld_i  (fetch_i.valid),
		.hazard_i     (hazard),
		.freed_cnt_i  (freed_cnt),
		.enter_o      (enter),
		.enter_vld_o  (enter_vld),
		.dcd_id_o     (dcd_id),
		.dcd_vld_o    (dcd_vld),
		.dsptc_id_o   (dsptc_id),
		.dsptc_vld_o  (dsptc_vld),
		.retire_id_o  (retire_id),
		.retire_vld_o (retire_vld),
		.chk_rs1_o    (chk_rs1),
		.chk_rs2_o    (chk_rs2),
		.chk_rd_o     (chk_rd),
		.retire_o     (retire_o),
		.credit_o     (credit_o),
		.credit_cnt_o (credit_cnt_o)
	);

	dpc_monitor #(
		.trace_depth (trace_depth),
		.en_bypass   (en_bypass)
	) u_dpc_monitor (
		.clk          (clk),
		.resetn       (resetn),
		.flush_i      (flush_i),
		.enter_i      (enter),
		.enter_vld_i  (enter_vld),
		.dcd_id_i     (dcd_id),
		.dcd_vld_i    (dcd_vld),
		.dsptc_id_i   (dsptc_id),
		.dsptc_vld_i  (dsptc_vld),
		.retire_id_i  (retire_id),
		.retire_vld_i (retire_vld),
		.chk_rs1_i    (chk_rs1),
		.chk_rs2_i    (chk_rs2),
		.chk_rd_i     (chk_rd),
		.hazard_o     (hazard),
		.freed_cnt_o  (freed_cnt),
		.full_o       ()
	);

endmodule

/* issue_ctrl.sv */
// In-order issue: fetch queue, decode register, single-cycle and long units, retire.
// long_lat must be at least 1. One retirement per cycle; a long result wins a tie
// and the single-cycle result waits one cycle in the hold register.
`timescale 1ns/1ps

module issue_ctrl #(
	parameter int trace_depth = 4,
	parameter int long_lat    = 4
)(
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             flush_i,
	input  dpc_pkg::trace_entry_t            entry_i,
	input  logic                             entry_vld_i,
	input  dpc_pkg::hazard_t                 hazard_i,
	input  logic [$clog2(trace_depth+1)-1:0] freed_cnt_i,
	output dpc_pkg::trace_entry_t            enter_o,
	output logic                             enter_vld_o,
	output dpc_pkg::inst_id_t                dcd_id_o,
	output logic                             dcd_vld_o,
	output dpc_pkg::inst_id_t                dsptc_id_o,
	output logic                             dsptc_vld_o,
	output dpc_pkg::inst_id_t                retire_id_o,
	output logic                             retire_vld_o,
	output rv_isa_pkg::reg_idx_t             chk_rs1_o,
	output rv_isa_pkg::reg_idx_t             chk_rs2_o,
	output rv_isa_pkg::reg_idx_t             chk_rd_o,
	output dpc_pkg::retire_pkt_t             retire_o,
	output logic                             credit_o,
	output logic [$clog2(trace_depth+1)-1:0] credit_cnt_o
);
	import dpc_pkg::*;

	localparam int CNT_W = $clog2(trace_depth + 1);
	localparam int PTR_W = (trace_depth > 1) ? $clog2(trace_depth) : 1;
	localparam int LAT_W = $clog2(long_lat + 1);

	trace_entry_t       fq_mem [trace_depth];
	logic [PTR_W-1:0]   wr_ptr;
	logic [PTR_W-1:0]   rd_ptr;
	logic [CNT_W-1:0]   fq_cnt;
	inst_id_t           id_q;
	logic               push;
	logic               dcd_ld;
	trace_entry_t       dr_q; // decode register
	logic               dr_vld;
	logic               dsp_fire;
	logic               sc_free;
	logic               lu_free;
	retire_pkt_t        sc_q;
	retire_pkt_t        hold_q;
	retire_pkt_t        lu_q;
	logic [LAT_W-1:0]   lu_cnt;
	logic               long_fin;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(trace_depth - 1)) ? '0 : p + 1'b1;
	endfunction

	always_comb
	begin
		enter_o         = entry_i;
		enter_o.inst_id = id_q;
	end
	assign enter_vld_o = entry_vld_i;

	assign push   = entry_vld_i && !flush_i;
	assign dcd_ld = (fq_cnt != '0) && (!dr_vld || dsp_fire) && !flush_i;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			fq_cnt <= '0;
			id_q   <= '0;
		end
		else
		begin
			if (entry_vld_i)
				id_q <= id_q + 1'b1;
			if (flush_i)
			begin
				wr_ptr <= '0;
				rd_ptr <= '0;
				fq_cnt <= '0;
			end
			else
			begin
				if (push)
					wr_ptr <= ptr_inc(wr_ptr);
				if (dcd_ld)
					rd_ptr <= ptr_inc(rd_ptr);
				fq_cnt <= fq_cnt + CNT_W'(push) - CNT_W'(dcd_ld);
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			fq_mem[wr_ptr] <= enter_o;
		if (dcd_ld)
			dr_q <= fq_mem[rd_ptr];
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			dr_vld <= 1'b0;
		else if (flush_i)
			dr_vld <= 1'b0;
		else if (dcd_ld)
			dr_vld <= 1'b1;
		else if (dsp_fire)
			dr_vld <= 1'b0;
	end

	assign dcd_vld_o = dcd_ld;
	assign dcd_id_o  = fq_mem[rd_ptr].inst_id;
	assign chk_rs1_o = dr_q.rs1;
	assign chk_rs2_o = dr_q.rs2;
	assign chk_rd_o  = dr_q.rd;

	// no single-cycle issue while the hold register is full or filling
	assign long_fin = lu_q.valid && (lu_cnt == '0);
	assign sc_free  = !hold_q.valid && !(long_fin && sc_q.valid);
	assign lu_free  = !lu_q.valid || long_fin;
	assign dsp_fire = dr_vld && !hazard_i.rs1_raw && !hazard_i.rs2_raw && !hazard_i.rd_waw &&
		(dr_q.is_long ? lu_free : sc_free);

	assign dsptc_vld_o = dsp_fire;
	assign dsptc_id_o  = dr_q.inst_id;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			sc_q   <= '0;
			hold_q <= '0;
			lu_q   <= '0;
			lu_cnt <= '0;
		end
		else
		begin
			sc_q <= '{valid: dsp_fire && !dr_q.is_long, inst_id: dr_q.inst_id,
				rd: dr_q.rd, is_long: 1'b0};
			if (long_fin && sc_q.valid)
				hold_q <= sc_q;
			else if (!long_fin)
				hold_q.valid <= 1'b0; // retired this cycle or already empty
			if (dsp_fire && dr_q.is_long)
			begin
				lu_q   <= '{valid: 1'b1, inst_id: dr_q.inst_id, rd: dr_q.rd, is_long: 1'b1};
				lu_cnt <= LAT_W'(long_lat - 1);
			end
			else if (long_fin)
				lu_q.valid <= 1'b0;
			else if (lu_q.valid)
				lu_cnt <= lu_cnt - 1'b1;
		end
	end

	always_comb
	begin
		if (long_fin)
			retire_o = lu_q;
		else if (hold_q.valid)
			retire_o = hold_q;
		else
			retire_o = sc_q;
	end

	assign retire_vld_o = retire_o.valid;
	assign retire_id_o  = retire_o.inst_id;

	// credits trail the freeing by one cycle
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			credit_cnt_o <= '0;
		else
			credit_cnt_o <= freed_cnt_i;
	end
	assign credit_o = (credit_cnt_o != '0);

endmodule

/* dpc_monitor.sv */
// Tracks up to trace_depth instructions from fetch queue entry to retirement.
// The instruction in the decode register is the only one in IN_DSPTC_MSG, so only
// executing entries can be producers for its RAW and bypass checks.
`timescale 1ns/1ps

module dpc_monitor #(
	parameter int trace_depth = 4,
	parameter int en_bypass   = 1
)(
	input  logic                             clk,
	input  logic                             resetn,
	input  logic                             flush_i,
	input  dpc_pkg::trace_entry_t            enter_i,
	input  logic                             enter_vld_i,
	input  dpc_pkg::inst_id_t                dcd_id_i,
	input  logic                             dcd_vld_i,
	input  dpc_pkg::inst_id_t                dsptc_id_i,
	input  logic                             dsptc_vld_i,
	input  dpc_pkg::inst_id_t                retire_id_i,
	input  logic                             retire_vld_i,
	input  rv_isa_pkg::reg_idx_t             chk_rs1_i,
	input  rv_isa_pkg::reg_idx_t             chk_rs2_i,
	input  rv_isa_pkg::reg_idx_t             chk_rd_i,
	output dpc_pkg::hazard_t                 hazard_o,
	output logic [$clog2(trace_depth+1)-1:0] freed_cnt_o,
	output logic                             full_o
);
	import dpc_pkg::*;

	localparam int CNT_W = $clog2(trace_depth + 1);

	logic [trace_depth-1:0] free_vec;
	logic [trace_depth-1:0] grant_vec;
	logic [trace_depth-1:0] rel_vec; // entry goes back to NOT_VALID this cycle
	logic [trace_depth-1:0] long_vec;
	logic [trace_depth-1:0] rs1_m;
	logic [trace_depth-1:0] rs2_m;
	logic [trace_depth-1:0] waw_m;
	logic                   no_bypass;

	assign grant_vec = free_vec & (~free_vec + 1'b1); // lowest free entry first
	assign full_o    = ~|free_vec;
	assign no_bypass = (en_bypass == 0);

	for (genvar g = 0; g < trace_depth; g++)
	begin : g_ent
		dpc_stage_e   stage_q;
		dpc_stage_e   stage_nxt;
		trace_entry_t rec_q;
		logic         hit_dcd;
		logic         hit_dsp;
		logic         hit_ret;
		logic         prod;
		logic         rd_nz;

		assign hit_dcd = dcd_vld_i && (rec_q.inst_id == dcd_id_i);
		assign hit_dsp = dsptc_vld_i && (rec_q.inst_id == dsptc_id_i);
		assign hit_ret = retire_vld_i && (rec_q.inst_id == retire_id_i);

		always_comb
		begin
			stage_nxt = stage_q;
			case (stage_q)
				NOT_VALID:
					if (enter_vld_i && grant_vec[g] && !flush_i)
						stage_nxt = IN_IFQ;
				IN_IFQ:
					if (flush_i)
						stage_nxt = NOT_VALID;
					else if (hit_dcd)
						stage_nxt = IN_DSPTC_MSG;
				IN_DSPTC_MSG:
					if (hit_dsp)
						stage_nxt = hit_ret ? NOT_VALID : IN_EXU; // dispatched, survives flush
					else if (flush_i)
						stage_nxt = NOT_VALID;
				IN_EXU:
					if (hit_ret)
						stage_nxt = NOT_VALID;
				default:
					stage_nxt = NOT_VALID;
			endcase
		end

		always_ff @(posedge clk or negedge resetn)
		begin
			if (!resetn)
				stage_q <= NOT_VALID;
			else
				stage_q <= stage_nxt;
		end

		always_ff @(posedge clk)
		begin
			if (enter_vld_i && grant_vec[g])
				rec_q <= enter_i;
		end

		assign free_vec[g] = (stage_q == NOT_VALID);
		assign rel_vec[g]  = (stage_q != NOT_VALID) && (stage_nxt == NOT_VALID);
		assign long_vec[g] = rec_q.is_long;

		assign prod  = (stage_q == IN_EXU); // only dispatched work produces results
		assign rd_nz = (rec_q.rd != '0);

		assign rs1_m[g] = prod && rd_nz && (rec_q.rd == chk_rs1_i);
		assign rs2_m[g] = prod && rd_nz && (rec_q.rd == chk_rs2_i);
		// only a long op still in flight can finish after a later writer
		assign waw_m[g] = (stage_q == IN_EXU) && rec_q.is_long && rd_nz &&
			(rec_q.rd == chk_rd_i);
	end

	assign hazard_o.rs1_raw   = |(rs1_m & (long_vec | {trace_depth{no_bypass}}));
	assign hazard_o.rs2_raw   = |(rs2_m & (long_vec | {trace_depth{no_bypass}}));
	assign hazard_o.rd_waw    = |waw_m;
	assign hazard_o.p0_bypass = !no_bypass && |(rs1_m & ~long_vec);
	assign hazard_o.p1_bypass = !no_bypass && |(rs2_m & ~long_vec);

	// an enter during flush is dropped at once, its credit goes back too
	always_comb
	begin
		freed_cnt_o = CNT_W'(flush_i && enter_vld_i);
		for (int i = 0; i < trace_depth; i++)
			freed_cnt_o = freed_cnt_o + CNT_W'(rel_vec[i]);
	end

endmodule

/* inst_predecode.sv */
// Combinational predecode of one fetched word.
// Opcodes outside OP, OP-IMM, LOAD, STORE, LUI and AUIPC write no rd and read no rs2.
`timescale 1ns/1ps

module inst_predecode (
	input  rv_isa_pkg::rv_inst_u inst_i,
	output rv_isa_pkg::reg_idx_t rd_o,
	output rv_isa_pkg::reg_idx_t rs1_o,
	output rv_isa_pkg::reg_idx_t rs2_o,
	output logic                 rd_vld_o,
	output logic                 rs2_vld_o,
	output logic                 is_long_o
);
	import rv_isa_pkg::*;

	opcode_t opc;
	logic    is_op;
	logic    is_op_imm;
	logic    is_load;
	logic    is_store;
	logic    is_upper;
	logic    ld_ok;
	logic    is_muldiv;

	assign opc = inst_i.r.opcode;

	assign is_op     = (opc == OPC_OP);
	assign is_op_imm = (opc == OPC_OP_IMM);
	assign is_store  = (opc == OPC_STORE);
	assign is_upper  = (opc == OPC_LUI) || (opc == OPC_AUIPC);

	// funct3 through the i view picks out legal load widths
	always_comb
	begin
		case (inst_i.i.funct3)
			F3_LB, F3_LH, F3_LW, F3_LBU, F3_LHU:
				ld_ok = 1'b1;
			default:
				ld_ok = 1'b0;
		endcase
	end

	assign is_load   = (opc == OPC_LOAD) && ld_ok;
	assign is_muldiv = is_op && (inst_i.r.funct7 == FUNCT7_MULDIV);

	assign rd_o  = inst_i.i.rd;
	assign rs1_o = is_upper ? '0 : inst_i.i.rs1; // U-type has immediate bits there
	assign rs2_o = inst_i.r.rs2;

	assign rd_vld_o  = is_op || is_op_imm || is_load || is_upper;
	assign rs2_vld_o = is_op || is_store;
	assign is_long_o = is_load || is_muldiv; // loads and mul/div go to the long unit

endmodule

/* dpc_pkg.sv */
// Types shared by the dependency monitor and the issue control.
// inst_id_t is 8 bits, so at most 256 instructions may be tracked at once.
package dpc_pkg;

	// life stage of a tracked instruction, one-hot
	typedef enum logic [3:0] {
		NOT_VALID    = 4'b0001,
		IN_IFQ       = 4'b0010,
		IN_DSPTC_MSG = 4'b0100,
		IN_EXU       = 4'b1000
	} dpc_stage_e;

	typedef logic [7:0] inst_id_t;

	// upstream word, only sent while a credit is held
	typedef struct packed {
		logic        valid;
		logic [31:0] inst;
	} fetch_pkt_t;

	typedef struct packed {
		rv_isa_pkg::reg_idx_t rd; // 0 when rd is not written
		rv_isa_pkg::reg_idx_t rs1;
		rv_isa_pkg::reg_idx_t rs2;
		logic                 is_long;
		inst_id_t             inst_id;
	} trace_entry_t;

	typedef struct packed {
		logic                 valid;
		inst_id_t             inst_id;
		rv_isa_pkg::reg_idx_t rd;
		logic                 is_long;
	} retire_pkt_t;

	typedef struct packed {
		logic rs1_raw;
		logic rs2_raw;
		logic rd_waw;
		logic p0_bypass; // rs1 served by a single-cycle producer
		logic p1_bypass; // same for rs2
	} hazard_t;

endpackage

/* rv_isa_pkg.sv */
// RV32I/M instruction word fields and the base opcodes used by the issue core.
// Only the R and I layouts are decoded here; store and upper immediates are not split out.
package rv_isa_pkg;

	typedef logic [4:0] reg_idx_t;
	typedef logic [6:0] opcode_t;

	localparam opcode_t OPC_OP     = 7'b0110011;
	localparam opcode_t OPC_OP_IMM = 7'b0010011;
	localparam opcode_t OPC_LOAD   = 7'b0000011;
	localparam opcode_t OPC_STORE  = 7'b0100011;
	localparam opcode_t OPC_LUI    = 7'b0110111;
	localparam opcode_t OPC_AUIPC  = 7'b0010111;

	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001; // M extension

	// load widths accepted as real loads
	localparam logic [2:0] F3_LB  = 3'b000;
	localparam logic [2:0] F3_LH  = 3'b001;
	localparam logic [2:0] F3_LW  = 3'b010;
	localparam logic [2:0] F3_LBU = 3'b100;
	localparam logic [2:0] F3_LHU = 3'b101;

	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		opcode_t    opcode;
	} rv_r_t;

	typedef struct packed {
		logic [11:0] imm;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		opcode_t     opcode;
	} rv_i_t;

	// one word, two views
	typedef union packed {
		rv_r_t r;
		rv_i_t i;
	} rv_inst_u;

endpackage
